// ==== Bender.yml ====
package:
  name: branch_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/branch_pkg.sv
      - src/branch_cond_eval.sv
      - src/branchmiss_pc.sv
      - src/stream_alloc.sv
      - src/branch_unit.sv
  - target: simulation
    include_dirs:
      - src
      - verif
    files:
      - verif/tb_branch_unit.sv

// ==== compile.f ====
+incdir+src
+incdir+verif
src/branch_pkg.sv
src/branch_cond_eval.sv
src/branchmiss_pc.sv
src/stream_alloc.sv
src/branch_unit.sv
verif/tb_branch_unit.sv

// ==== src/branch_cond_eval.sv ====
// branch condition evaluator comparing operands A and B for the taken decision
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_cond_eval (
	input  branch_pkg::br_cond_e cond,
	input  logic [63:0]          arg_a,
	input  logic [63:0]          arg_b,
	output logic                 takb
);

	import branch_pkg::*;

	// only the low six bits of B select a bit in the 64-bit A operand
	logic [5:0] bit_sel;

	// the selected bit of A, shared by both bit tests
	logic       a_bit;

	// signed view of the operands for the relational tests
	logic signed [63:0] sa;
	logic signed [63:0] sb;

	assign bit_sel = arg_b[5:0];
	assign a_bit   = arg_a[bit_sel];
	assign sa      = arg_a;
	assign sb      = arg_b;

	// ======================================================================
	// condition decode
	// ======================================================================

	always_comb
	begin
		case (cond)
			BC_EQ:
				takb = (arg_a == arg_b);
			BC_NE:
				takb = (arg_a != arg_b);
			// signed compares use the two's complement view
			BC_LT:
				takb = (sa < sb);
			BC_GE:
				takb = (sa >= sb);
			// unsigned compares work on the raw vectors
			BC_LTU:
				takb = (arg_a < arg_b);
			BC_GEU:
				takb = (arg_a >= arg_b);
			// bit tests ignore the upper bits of B
			BC_BS:
				takb = a_bit;
			BC_BC:
				takb = ~a_bit;
			default:
				takb = 1'b0;
		endcase
	end

endmodule

// ==== src/branch_macros.svh ====
// branch unit constants shared by the package and every RTL block
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// ======================================================================
// address and stream sizing
// ======================================================================

// width of an instruction address in bits
`define BR_ABITS 64

// width of a stream id, wide enough for the back end's full stream space
`define BR_STREAM_BITS 7

// number of stream ids managed by the free pool
// ids 0 and 1 are reserved so only 2 and up are ever handed out
`define BR_NUM_STREAMS 16

// ======================================================================
// machine state sizing
// ======================================================================

// entries in the interrupt return PC stack
`define BR_ISTACK_DEPTH 4

// number of operating modes, the top one is the most privileged
`define BR_NUM_OM 4

// instruction length in bytes, also the fall-through increment
`define BR_INSN_LEN 6

// restart address taken when the op carries no branch kind
`define BR_RSTPC 64'hFFFF_FFFF_FFFC_0000

`endif

// ==== src/branch_pkg.sv ====
// branch unit package with the micro-op, PC and redirect types plus mode helper
`include "branch_macros.svh"

package branch_pkg;

	// ======================================================================
	// basic scalar types
	// ======================================================================

	// a bare instruction address
	typedef logic [`BR_ABITS-1:0] addr_t;

	// stream id, each speculative path owns one
	typedef logic [`BR_STREAM_BITS-1:0] stream_t;

	// operating mode, indexes the per-mode vector tables
	typedef logic [$clog2(`BR_NUM_OM)-1:0] om_t;

	// PC extended with the stream it was fetched on
	typedef struct packed {
		stream_t stream;
		addr_t   pc;
	} pc_addr_ex_t;

	// ======================================================================
	// opcode classes
	// ======================================================================

	// branch kind as resolved by the decoder upstream
	typedef enum logic [2:0] {
		BK_NONE,
		BK_BCC,
		BK_BOI,
		BK_BSR,
		BK_JSR,
		BK_SYS,
		BK_ERET,
		BK_RET
	} br_kind_e;

	// condition tested by bcc and boi, the last two test a single bit of A
	typedef enum logic [2:0] {
		BC_EQ,
		BC_NE,
		BC_LT,
		BC_GE,
		BC_LTU,
		BC_GEU,
		BC_BS,
		BC_BC
	} br_cond_e;

	// flavor of system entry, picks between the two vector tables
	typedef enum logic {
		SK_SYSCALL,
		SK_KERNEL
	} sys_kind_e;

	// ======================================================================
	// issue and result records
	// ======================================================================

	// one issued branch micro-op with its operands already read
	typedef struct packed {
		pc_addr_ex_t pc;
		br_kind_e    kind;
		br_cond_e    cond;
		sys_kind_e   sys_kind;
		logic        md;
		logic        use_vector;
		logic [34:0] disp;
		om_t         om;
		logic [3:0]  eret_adj;
		logic        eret_level;
		logic [63:0] arg_a;
		logic [63:0] arg_b;
		logic [63:0] arg_c;
		logic        bt;
	} br_op_t;

	// redirect record sent back to the front end and the stream tracker
	typedef struct packed {
		logic        miss;
		pc_addr_ex_t misspc;
		pc_addr_ex_t dstpc;
		stream_t     kept_stream;
		logic        alloc;
		logic        takb;
	} redirect_t;

	// next higher operating mode, system entries never go past the top one
	function automatic om_t fn_next_om(input om_t om);
		if (om == om_t'(`BR_NUM_OM - 1))
			return om;
		return om + om_t'(1);
	endfunction

endpackage

// ==== src/branch_unit.sv ====
// branch resolution unit top, two register stages around the redirect logic
`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_unit (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           issue_valid,
	input  branch_pkg::br_op_t                             issue_op,
	input  branch_pkg::pc_addr_ex_t [`BR_ISTACK_DEPTH-1:0] pc_stack,
	input  branch_pkg::addr_t                              vector,
	input  branch_pkg::addr_t [`BR_NUM_OM-1:0]             syscall_vector,
	input  branch_pkg::addr_t [`BR_NUM_OM-1:0]             kernel_vector,
	input  logic                                           release_valid,
	input  branch_pkg::stream_t                            release_stream,
	output logic                                           result_valid,
	output branch_pkg::redirect_t                          result,
	output logic                                           pool_empty
);

	import branch_pkg::*;

	// stage 1 holds the issued op while the blocks below resolve it
	br_op_t      s1_op;
	logic        s1_valid;

	logic        takb;
	stream_t     new_stream;
	pc_addr_ex_t dstpc;
	pc_addr_ex_t misspc;
	stream_t     kept_stream;
	logic        alloc_new_stream;
	logic        miss;

	// only a live op may take an id out of the pool
	logic        pop_req;

	assign pop_req = s1_valid & alloc_new_stream;

	// ======================================================================
	// stage 1 register
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= issue_valid;
		if (issue_valid)
			s1_op <= issue_op;
	end

	branch_cond_eval branch_cond_eval_inst (
		.cond  (s1_op.cond),
		.arg_a (s1_op.arg_a),
		.arg_b (s1_op.arg_b),
		.takb  (takb)
	);

	stream_alloc stream_alloc_inst (
		.clk            (clk),
		.rst            (rst),
		.alloc          (pop_req),
		.release_valid  (release_valid),
		.release_stream (release_stream),
		.new_stream     (new_stream),
		.pool_empty     (pool_empty)
	);

	branchmiss_pc branchmiss_pc_inst (
		.op               (s1_op),
		.takb             (takb),
		.pc_stack         (pc_stack),
		.vector           (vector),
		.syscall_vector   (syscall_vector),
		.kernel_vector    (kernel_vector),
		.new_stream       (new_stream),
		.dstpc            (dstpc),
		.misspc           (misspc),
		.kept_stream      (kept_stream),
		.alloc_new_stream (alloc_new_stream),
		.miss             (miss)
	);

	// ======================================================================
	// stage 2 redirect record
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result_valid <= 1'b0;
			result.miss  <= 1'b0;
		end
		else
		begin
			result_valid <= s1_valid;
			// the record keeps its last value between ops
			if (s1_valid)
			begin
				result.miss        <= miss;
				result.misspc      <= misspc;
				result.dstpc       <= dstpc;
				result.kept_stream <= kept_stream;
				result.alloc       <= alloc_new_stream;
				result.takb        <= takb;
			end
		end
	end

endmodule

// ==== src/branchmiss_pc.sv ====
// branch redirect logic forming destination PC, miss PC and stream bookkeeping
`timescale 1ns/1ps
`include "branch_macros.svh"

module branchmiss_pc (
	input  branch_pkg::br_op_t                               op,
	input  logic                                             takb,
	input  branch_pkg::pc_addr_ex_t [`BR_ISTACK_DEPTH-1:0]   pc_stack,
	input  branch_pkg::addr_t                                vector,
	input  branch_pkg::addr_t [`BR_NUM_OM-1:0]               syscall_vector,
	input  branch_pkg::addr_t [`BR_NUM_OM-1:0]               kernel_vector,
	input  branch_pkg::stream_t                              new_stream,
	output branch_pkg::pc_addr_ex_t                          dstpc,
	output branch_pkg::pc_addr_ex_t                          misspc,
	output branch_pkg::stream_t                              kept_stream,
	output logic                                             alloc_new_stream,
	output logic                                             miss
);

	import branch_pkg::*;

	// displacement is in half-words, so it is shifted left once after extension
	addr_t disp_ext;

	// address of the next sequential instruction
	addr_t fall_pc;

	// mode the system entry lands in
	om_t   sys_om;

	// eret return base and its adjustment in whole instructions
	addr_t eret_base;
	addr_t eret_off;

	assign disp_ext  = {{(`BR_ABITS - 36){op.disp[34]}}, op.disp, 1'b0};
	assign fall_pc   = op.pc.pc + addr_t'(`BR_INSN_LEN);
	assign sys_om    = fn_next_om(op.om);
	assign eret_base = op.eret_level ? pc_stack[1].pc : pc_stack[0].pc;
	assign eret_off  = addr_t'(op.eret_adj) * addr_t'(`BR_INSN_LEN);

	always_comb
	begin
		// the destination starts as the op's own PC so the stream carries over
		dstpc            = op.pc;
		misspc           = op.pc;
		kept_stream      = '0;
		alloc_new_stream = 1'b0;
		miss             = 1'b1;

		// ==================================================================
		// destination PC by branch kind
		// ==================================================================

		case (op.kind)
			BK_BOI, BK_BCC:
				begin
					// register-indirect form, boi may also jump through the vector
					if (op.md)
						dstpc.pc = (op.kind == BK_BOI && op.use_vector) ? vector : op.arg_c;
					else
						dstpc.pc = op.pc.pc + disp_ext;
				end
			BK_BSR:
				begin
					// PC relative call always starts a fresh path
					dstpc.pc         = op.pc.pc + disp_ext;
					dstpc.stream     = new_stream;
					alloc_new_stream = 1'b1;
				end
			BK_JSR:
				begin
					// absolute call, the displacement is the whole target
					dstpc.pc         = disp_ext;
					dstpc.stream     = new_stream;
					alloc_new_stream = 1'b1;
				end
			BK_SYS:
				begin
					// system entry goes through the table of the next higher mode
					if (op.sys_kind == SK_SYSCALL)
						dstpc.pc = syscall_vector[sys_om];
					else
						dstpc.pc = kernel_vector[sys_om];
					dstpc.stream     = new_stream;
					alloc_new_stream = 1'b1;
				end
			BK_ERET:
				dstpc.pc = eret_base + eret_off;
			BK_RET:
				dstpc.pc = addr_t'(op.arg_a);
			default:
				dstpc.pc = `BR_RSTPC;
		endcase

		// ==================================================================
		// redirect and stream bookkeeping
		// ==================================================================

		case (op.kind)
			BK_BOI, BK_BCC:
				begin
					miss = op.bt ^ takb;
					case ({op.bt, takb})
						// predicted not taken and not taken, nothing changes
						2'b00:
							begin
								misspc      = dstpc;
								kept_stream = '0;
							end
						// taken against the prediction, target runs on a new stream
						2'b01:
							begin
								misspc.pc        = dstpc.pc;
								misspc.stream    = new_stream;
								alloc_new_stream = 1'b1;
								kept_stream      = op.pc.stream;
							end
						// fell through against the prediction, so resume after the branch
						2'b10:
							begin
								misspc.pc        = fall_pc;
								misspc.stream    = new_stream;
								alloc_new_stream = 1'b1;
								kept_stream      = dstpc.stream;
							end
						// predicted taken and taken
						default:
							begin
								misspc.pc     = fall_pc;
								misspc.stream = op.pc.stream;
								kept_stream   = '0;
							end
					endcase
				end
			// unconditional jumps are never predicted and always redirect
			default:
				begin
					misspc      = dstpc;
					kept_stream = '0;
					miss        = 1'b1;
				end
		endcase
	end

endmodule

// ==== src/stream_alloc.sv ====
// free pool of stream ids kept as a circular FIFO with an entry count
`timescale 1ns/1ps
`include "branch_macros.svh"

module stream_alloc (
	input  logic                clk,
	input  logic                rst,
	input  logic                alloc,
	input  logic                release_valid,
	input  branch_pkg::stream_t release_stream,
	output branch_pkg::stream_t new_stream,
	output logic                pool_empty
);

	import branch_pkg::*;

	localparam int DEPTH    = `BR_NUM_STREAMS;
	localparam int PTR_W    = $clog2(DEPTH);
	// ids below this are reserved and never enter the pool
	localparam int FIRST_ID = 2;

	stream_t            pool [DEPTH];
	logic [PTR_W-1:0]   head;
	logic [PTR_W-1:0]   tail;
	logic [PTR_W:0]     count;

	// pop and push qualified against the current fill level
	logic               do_pop;
	logic               do_push;

	assign pool_empty = (count == '0);

	// an empty pool hands out id 0, the caller sees that as no stream
	assign new_stream = pool_empty ? '0 : pool[head];

	assign do_pop  = alloc & ~pool_empty;

	// a release into a full pool is only taken if a pop frees a slot
	assign do_push = release_valid & ((count != (PTR_W+1)'(DEPTH)) | do_pop);

	// ======================================================================
	// pool state
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// preload the usable ids in ascending order
			for (int i = 0; i < DEPTH; i++)
				pool[i] <= (i < DEPTH - FIRST_ID) ? stream_t'(i + FIRST_ID) : '0;
			head  <= '0;
			tail  <= PTR_W'(DEPTH - FIRST_ID);
			count <= (PTR_W+1)'(DEPTH - FIRST_ID);
		end
		else
		begin
			if (do_push)
			begin
				pool[tail] <= release_stream;
				tail       <= tail + 1'b1;
			end
			if (do_pop)
				head <= head + 1'b1;
			// both strobes on one edge leave the count unchanged
			case ({do_push, do_pop})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count;
			endcase
		end
	end

endmodule

// ==== verif/branch_vectors.svh ====
// branch unit stimulus table with the condition operands and the expected taken outcome
`ifndef BRANCH_VECTORS_SVH
`define BRANCH_VECTORS_SVH

// flags nibble is {md, use_vector, sys_kind, eret_level}
typedef struct {
	string       name;
	br_kind_e    kind;
	br_cond_e    cond;
	logic        bt;
	logic [3:0]  flags;
	om_t         om;
	logic [3:0]  adj;
	logic [34:0] disp;
	logic [63:0] arg_a;
	logic [63:0] arg_b;
	logic        exp_takb;
} vec_row_t;

vec_row_t rows[$];

task automatic add_row(input string nm, input br_kind_e k, input br_cond_e c, input logic bt,
		input logic [3:0] fl, input om_t om, input logic [3:0] adj, input logic [34:0] d,
		input logic [63:0] a, input logic [63:0] b, input logic tk);
	vec_row_t r;
	r = '{nm, k, c, bt, fl, om, adj, d, a, b, tk};
	rows.push_back(r);
endtask

task automatic load_vectors();
	// name          kind     cond   bt flags om adj disp   arg_a   arg_b   takb
	add_row("eq_nt_nt",  BK_BCC, BC_EQ,  0, 4'h0, 0, 0, 35'h10, 64'd5, 64'd6, 0);
	add_row("ne_nt_tk",  BK_BCC, BC_NE,  0, 4'h0, 0, 0, 35'h10, 64'd5, 64'd6, 1);
	add_row("lt_tk_nt",  BK_BCC, BC_LT,  1, 4'h0, 0, 0, 35'h24, 64'd1, '1, 0);
	add_row("ge_tk_tk",  BK_BCC, BC_GE,  1, 4'h0, 0, 0, 35'h24, 64'd1, '1, 1);
	add_row("ltu_nt_tk", BK_BCC, BC_LTU, 0, 4'h0, 0, 0, 35'h7FFFFFFF0, 64'd1, '1, 1);
	add_row("geu_tk_nt", BK_BCC, BC_GEU, 1, 4'h0, 0, 0, 35'h7FFFFFFF0, 64'd1, '1, 0);
	// upper bits of B must not disturb the bit select
	add_row("bs_tk_tk",  BK_BCC, BC_BS,  1, 4'h0, 0, 0, 35'h20, 64'h8000000000000000,
		64'h10000000003F, 1);
	add_row("bc_nt_nt",  BK_BCC, BC_BC,  0, 4'h0, 0, 0, 35'h20, 64'h8000000000000000,
		64'h3F, 0);
	add_row("eq_md_tk",  BK_BCC, BC_EQ,  0, 4'h8, 0, 0, 35'h0, 64'd7, 64'd7, 1);
	add_row("boi_vec_nt", BK_BOI, BC_NE, 1, 4'hC, 0, 0, 35'h0, 64'd7, 64'd7, 0);
	add_row("boi_disp_tk", BK_BOI, BC_LT, 1, 4'h0, 0, 0, 35'h7FFFFFF00, -64'd5, 64'd3, 1);
	add_row("bsr_back",  BK_BSR, BC_EQ,  0, 4'h0, 0, 0, 35'h7FFFFFF00, 64'd0, 64'd0, 1);
	add_row("jsr_abs",   BK_JSR, BC_NE,  0, 4'h0, 0, 0, 35'h001234450, 64'd0, 64'd0, 0);
	add_row("sys_call_om0", BK_SYS, BC_EQ, 0, 4'h0, 0, 0, 35'h0, 64'd1, 64'd1, 1);
	add_row("sys_kern_om2", BK_SYS, BC_GEU, 0, 4'h2, 2, 0, 35'h0, 64'd2, 64'd1, 1);
	add_row("sys_call_om3", BK_SYS, BC_LTU, 0, 4'h0, 3, 0, 35'h0, 64'd2, 64'd1, 0);
	add_row("eret_lvl0", BK_ERET, BC_BS, 0, 4'h0, 0, 3, 35'h0, 64'h10, 64'd4, 1);
	add_row("eret_lvl1", BK_ERET, BC_BC, 0, 4'h1, 0, 15, 35'h0, 64'h10, 64'd4, 0);
	add_row("ret_arg_a", BK_RET, BC_NE,  0, 4'h0, 0, 0, 35'h0, 64'h123456789ABCDEF0, 64'd0, 1);
	add_row("none_rst",  BK_NONE, BC_EQ, 0, 4'h0, 0, 0, 35'h0, 64'd0, 64'd1, 0);
endtask

`endif

// ==== verif/tb_branch_unit.sv ====
// branch unit testbench driving a table of ops and checking each redirect record
`timescale 1ns/1ps
`include "branch_macros.svh"

module tb_branch_unit;

	import branch_pkg::*;

	`include "branch_vectors.svh"

	// one outstanding op with the record it should produce
	typedef struct {
		string     name;
		int        cycle;
		redirect_t r;
	} pend_t;

	logic                                 clk = 1'b0;
	logic                                 rst;
	logic                                 issue_valid;
	br_op_t                               issue_op;
	pc_addr_ex_t [`BR_ISTACK_DEPTH-1:0]   pc_stack;
	addr_t                                vector;
	addr_t [`BR_NUM_OM-1:0]               syscall_vector;
	addr_t [`BR_NUM_OM-1:0]               kernel_vector;
	logic                                 release_valid;
	stream_t                              release_stream;
	logic                                 result_valid;
	redirect_t                            result;
	logic                                 pool_empty;

	int      errors = 0;
	int      checks = 0;
	int      cycle_cnt = 0;
	int      n;
	pend_t   exp_q[$];
	pend_t   cur;
	stream_t pool_q[$];

	branch_unit branch_unit_inst (
		.clk            (clk),
		.rst            (rst),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.pc_stack       (pc_stack),
		.vector         (vector),
		.syscall_vector (syscall_vector),
		.kernel_vector  (kernel_vector),
		.release_valid  (release_valid),
		.release_stream (release_stream),
		.result_valid   (result_valid),
		.result         (result),
		.pool_empty     (pool_empty)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// ======================================================================
	// checking helpers and reference model
	// ======================================================================

	task automatic check_field(input string nm, input string what, input logic [127:0] exp,
			input logic [127:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("Fail %s %s expected %0h actual %0h", nm, what, exp, act);
		end
	endtask

	// model of the free pool, an empty pool hands out id 0
	function automatic stream_t take_stream();
		if (pool_q.size() == 0)
			return '0;
		return pool_q.pop_front();
	endfunction

	// halfword displacement sign extended to a byte offset
	function automatic addr_t branch_offset(input logic [34:0] d);
		return {{29{d[34]}}, d} << 1;
	endfunction

	task automatic predict(input br_op_t op, input logic tk, output redirect_t r);
		addr_t   target;
		addr_t   next_pc;
		stream_t fresh;
		logic    need_new;
		om_t     sys_mode;
		logic    cond_br;
		r        = '0;
		r.takb   = tk;
		cond_br  = (op.kind == BK_BCC) || (op.kind == BK_BOI);
		next_pc  = op.pc.pc + addr_t'(`BR_INSN_LEN);
		need_new = 1'b0;
		// system entries move up one mode but stop at the top one
		sys_mode = (op.om == om_t'(`BR_NUM_OM - 1)) ? op.om : op.om + 1'b1;
		case (op.kind)
			BK_BCC, BK_BOI:
			begin
				if (!op.md)
					target = op.pc.pc + branch_offset(op.disp);
				else if (op.kind == BK_BOI && op.use_vector)
					target = vector;
				else
					target = op.arg_c;
				need_new = op.bt ^ tk;
			end
			BK_BSR:
			begin
				target   = op.pc.pc + branch_offset(op.disp);
				need_new = 1'b1;
			end
			BK_JSR:
			begin
				target   = branch_offset(op.disp);
				need_new = 1'b1;
			end
			BK_SYS:
			begin
				target = (op.sys_kind == SK_KERNEL) ? kernel_vector[sys_mode]
					: syscall_vector[sys_mode];
				need_new = 1'b1;
			end
			BK_ERET:
				target = pc_stack[op.eret_level].pc + addr_t'(op.eret_adj) * addr_t'(6);
			BK_RET:
				target = op.arg_a;
			default:
				target = `BR_RSTPC;
		endcase
		fresh          = need_new ? take_stream() : '0;
		r.alloc        = need_new;
		r.dstpc.pc     = target;
		r.dstpc.stream = (need_new && !cond_br) ? fresh : op.pc.stream;
		r.miss         = cond_br ? (op.bt ^ tk) : 1'b1;
		r.misspc       = r.dstpc;
		if (cond_br && !op.bt && tk)
		begin
			r.misspc.stream = fresh;
			r.kept_stream   = op.pc.stream;
		end
		else if (cond_br && op.bt)
		begin
			// a taken prediction resumes after the branch, on a new path if it fell through
			r.misspc.pc     = next_pc;
			r.misspc.stream = tk ? op.pc.stream : fresh;
			r.kept_stream   = tk ? '0 : r.dstpc.stream;
		end
	endtask

	// ======================================================================
	// stimulus helpers
	// ======================================================================

	// drives one row for a single cycle, called 1 ns after a rising edge
	task automatic issue_row(input vec_row_t row);
		br_op_t op;
		pend_t  p;
		op            = '0;
		op.pc.stream  = stream_t'($urandom_range(2, 15));
		op.pc.pc      = {$urandom, $urandom};
		op.kind       = row.kind;
		op.cond       = row.cond;
		op.md         = row.flags[3];
		op.use_vector = row.flags[2];
		op.sys_kind   = sys_kind_e'(row.flags[1]);
		op.eret_level = row.flags[0];
		op.disp       = row.disp;
		op.om         = row.om;
		op.eret_adj   = row.adj;
		op.arg_a      = row.arg_a;
		op.arg_b      = row.arg_b;
		op.arg_c      = {$urandom, $urandom};
		op.bt         = row.bt;
		p.name        = row.name;
		p.cycle       = cycle_cnt + 2;
		predict(op, row.exp_takb, p.r);
		exp_q.push_back(p);
		issue_op    = op;
		issue_valid = 1'b1;
	endtask

	function automatic vec_row_t call_row(input string nm);
		return '{nm, BK_BSR, BC_EQ, 1'b0, 4'h0, '0, 4'h0, 35'h40, 64'd0, 64'd0, 1'b1};
	endfunction

	// each loop pass waits one cycle, so the limit bounds the wait to 10 cycles
	task automatic wait_drained(input string nm);
		int k;
		k = 0;
		while (exp_q.size() != 0 && k < 10)
		begin
			@(posedge clk);
			#1;
			k++;
		end
		assert (exp_q.size() == 0)
		else
		begin
			errors++;
			$display("Error: %s timed out waiting for result_valid", nm);
			exp_q.delete();
		end
	endtask

	task automatic single_call(input string nm);
		issue_row(call_row(nm));
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
		wait_drained(nm);
	endtask

	// results are sampled on the falling edge, well away from the register updates
	always @(negedge clk)
	begin
		if (!rst && result_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				errors++;
				$display("Error: result_valid was high with no op outstanding");
			end
			if (exp_q.size() != 0)
			begin
				cur = exp_q.pop_front();
				check_field(cur.name, "cycle", cur.cycle, cycle_cnt);
				check_field(cur.name, "takb", cur.r.takb, result.takb);
				check_field(cur.name, "miss", cur.r.miss, result.miss);
				check_field(cur.name, "dstpc", cur.r.dstpc, result.dstpc);
				check_field(cur.name, "misspc", cur.r.misspc, result.misspc);
				check_field(cur.name, "kept_stream", cur.r.kept_stream, result.kept_stream);
				check_field(cur.name, "alloc", cur.r.alloc, result.alloc);
			end
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================

	initial
	begin
		void'($urandom(92839));
		rst            = 1'b1;
		issue_valid    = 1'b0;
		issue_op       = '0;
		release_valid  = 1'b0;
		release_stream = '0;
		vector         = {$urandom, $urandom};
		for (int i = 0; i < `BR_ISTACK_DEPTH; i++)
			pc_stack[i] = {stream_t'($urandom_range(2, 15)), $urandom, $urandom};
		for (int i = 0; i < `BR_NUM_OM; i++)
		begin
			syscall_vector[i] = {$urandom, $urandom};
			kernel_vector[i]  = {$urandom, $urandom};
		end
		for (int i = 2; i < `BR_NUM_STREAMS; i++)
			pool_q.push_back(stream_t'(i));
		load_vectors();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_field("reset", "result_valid", 1'b0, result_valid);
		check_field("reset", "miss", 1'b0, result.miss);
		check_field("reset", "pool_empty", 1'b0, pool_empty);
		// the whole table goes out back to back, one op per cycle
		@(posedge clk);
		#1;
		foreach (rows[i])
		begin
			issue_row(rows[i]);
			@(posedge clk);
			#1;
		end
		issue_valid = 1'b0;
		wait_drained("table");
		// use up what is left of the modeled pool, the DUT must then report empty
		n = 0;
		while (pool_q.size() != 0 && n < `BR_NUM_STREAMS)
		begin
			single_call("drain_pool");
			n++;
		end
		check_field("drain_pool", "pool_empty", 1'b1, pool_empty);
		single_call("empty_alloc");
		check_field("empty_alloc", "pool_empty", 1'b1, pool_empty);
		// two releases come back in the order they went in
		release_valid  = 1'b1;
		release_stream = stream_t'(5);
		pool_q.push_back(stream_t'(5));
		@(posedge clk);
		#1;
		release_stream = stream_t'(2);
		pool_q.push_back(stream_t'(2));
		@(posedge clk);
		#1;
		release_valid = 1'b0;
		check_field("release", "pool_empty", 1'b0, pool_empty);
		single_call("reuse_first");
		single_call("reuse_second");
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
